// ==== cv_tile_engine.f ====
+incdir+include
rtl/cv_types_pkg.sv
rtl/cv_word_buffer.sv
rtl/cv_weights_handler.sv
rtl/cv_pixel_handler.sv
rtl/cv_dot_accumulator.sv
rtl/cv_tile_engine.sv
tests/cv_tile_engine_tb.sv

// ==== include/cv_consts.svh ====
`ifndef CV_CONSTS_SVH
`define CV_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// tile engine dimensions
//////////////////////////////////////////////////////////////////////

// multiply lanes per word
`define CV_LANES 64

// one byte per lane
`define CV_WORD_BITS (`CV_LANES * 8)

// packed 2-bit weights in mode 1 occupy the low part of the word
`define CV_BIN_BITS 128

// buffer addressing
`define CV_ADR_BITS 16
`define CV_BUF_DEPTH 256

// tile accumulator, signed
`define CV_ACC_BITS 32

`endif

// ==== rtl/cv_dot_accumulator.sv ====
`timescale 1ns/100ps
`include "cv_consts.svh"

module cv_dot_accumulator (
  input  logic                   clk,
  input  logic                   reset,
  input  cv_types_pkg::cv_word_t weights_vector,
  input  logic                   weight_valid,
  input  cv_types_pkg::cv_word_t pixel_vector,
  output cv_types_pkg::cv_acc_t  conv_result,
  output logic                   conv_done
);

  import cv_types_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // lane products
  //////////////////////////////////////////////////////////////////////

  // signed weight byte times unsigned pixel byte
  logic signed [16:0] prod [`CV_LANES];

  for (genvar i = 0; i < `CV_LANES; i++) begin : g_lane
    // pixel gets a zero sign bit
    assign prod[i] = $signed(weights_vector[i*8+:8]) * $signed({1'b0, pixel_vector[i*8+:8]});
  end

  //////////////////////////////////////////////////////////////////////
  // adder tree
  //////////////////////////////////////////////////////////////////////

  // heap layout, root at 0, leaves from CV_LANES-1 up
  cv_acc_t tree [2*`CV_LANES-1];
  cv_acc_t word_sum;

  for (genvar i = 0; i < `CV_LANES; i++) begin : g_leaf
    assign tree[`CV_LANES-1+i] = cv_acc_t'(prod[i]);
  end

  for (genvar n = 0; n < `CV_LANES-1; n++) begin : g_node
    assign tree[n] = tree[2*n+1] + tree[2*n+2];
  end

  assign word_sum = tree[0];

  //////////////////////////////////////////////////////////////////////
  // tile accumulation
  //////////////////////////////////////////////////////////////////////

  cv_acc_state_t state;
  cv_acc_t       acc;
  cv_acc_t       result_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= CV_ACC_IDLE;
      result_q <= '0;
    end else begin
      case (state)
        CV_ACC_IDLE: begin
          if (weight_valid) begin
            state <= CV_ACC_RUN;
          end
        end
        CV_ACC_RUN: begin
          // valid fell, tile complete
          if (!weight_valid) begin
            state    <= CV_ACC_IDLE;
            result_q <= acc;
          end
        end
        default: state <= CV_ACC_IDLE;
      endcase
    end
  end

  // first word loads, later words add
  always_ff @(posedge clk) begin
    if (weight_valid) begin
      if (state == CV_ACC_IDLE) begin
        acc <= word_sum;
      end else begin
        acc <= acc + word_sum;
      end
    end
  end

  // done in the cycle after the last word
  assign conv_done = (state == CV_ACC_RUN) && !weight_valid;

  // the fresh sum shows during done, then the held copy
  assign conv_result = conv_done ? acc : result_q;

endmodule

// ==== rtl/cv_pixel_handler.sv ====
`timescale 1ns/100ps
`include "cv_consts.svh"

module cv_pixel_handler (
  input  logic                   clk,
  input  logic                   reset,
  // tile strobes, cycle 0
  input  logic                   re_fm_en,
  input  logic                   re_fm_end,
  input  cv_types_pkg::cv_adr_t  fm_base,
  // buffer data, cycle 1
  input  cv_types_pkg::cv_word_t fm_dout,
  // buffer read request, cycle 0
  output logic                   fm_rd_en,
  output cv_types_pkg::cv_adr_t  fm_rd_adr,
  // pixels, cycle 1
  output cv_types_pkg::cv_word_t pixel_vector,
  output logic                   pixel_valid
);

  import cv_types_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // read counter with tile base
  //////////////////////////////////////////////////////////////////////

  cv_adr_t rd_cnt;
  cv_adr_t base_q;
  cv_adr_t base_sel;
  logic    first_rd;

  assign fm_rd_en = re_fm_en && !re_fm_end;

  // first read of a tile uses the live base
  assign first_rd = fm_rd_en && (rd_cnt == cv_adr_t'(1));

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_cnt <= cv_adr_t'(1);
    end else if (re_fm_en) begin
      if (re_fm_end) begin
        rd_cnt <= cv_adr_t'(1);
      end else begin
        rd_cnt <= rd_cnt + cv_adr_t'(1);
      end
    end
  end

  // base held for the rest of the tile
  always_ff @(posedge clk) begin
    if (first_rd) begin
      base_q <= fm_base;
    end
  end

  assign base_sel  = first_rd ? fm_base : base_q;
  assign fm_rd_adr = base_sel + rd_cnt - cv_adr_t'(1);

  //////////////////////////////////////////////////////////////////////
  // valid and lane gating
  //////////////////////////////////////////////////////////////////////

  // same rule as the weight side
  always_ff @(posedge clk) begin
    if (reset) begin
      pixel_valid <= 1'b0;
    end else if (re_fm_en) begin
      pixel_valid <= !re_fm_end;
    end
  end

  // unsigned bytes pass straight through
  assign pixel_vector = pixel_valid ? fm_dout : '0;

endmodule

// ==== rtl/cv_tile_engine.sv ====
`timescale 1ns/100ps
`include "cv_consts.svh"

module cv_tile_engine (
  input  logic                   clk,
  input  logic                   reset,
  // tile control
  input  cv_types_pkg::cv_mode_t mode,
  input  logic                   re_fm_en,
  input  logic                   re_fm_end,
  input  cv_types_pkg::cv_adr_t  fm_base,
  // weight buffer load
  input  logic                   w_wr_en,
  input  cv_types_pkg::cv_adr_t  w_wr_adr,
  input  cv_types_pkg::cv_word_t w_wr_data,
  // feature-map buffer load
  input  logic                   fm_wr_en,
  input  cv_types_pkg::cv_adr_t  fm_wr_adr,
  input  cv_types_pkg::cv_word_t fm_wr_data,
  // results
  output cv_types_pkg::cv_acc_t  conv_result,
  output logic                   conv_done,
  output logic                   tile_active
);

  import cv_types_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // internal wires
  //////////////////////////////////////////////////////////////////////

  // weight read path
  logic     w_rd_en;
  cv_adr_t  w_rd_adr;
  cv_word_t w_dout;

  // feature-map read path
  logic     fm_rd_en;
  cv_adr_t  fm_rd_adr;
  cv_word_t fm_dout;

  // aligned lanes into the accumulator
  cv_word_t weights_vector;
  logic     weight_valid;
  cv_word_t pixel_vector;

  //////////////////////////////////////////////////////////////////////
  // buffers
  //////////////////////////////////////////////////////////////////////

  cv_word_buffer i_weight_buf (
    .clk     (clk),
    .wr_en   (w_wr_en),
    .wr_adr  (w_wr_adr),
    .wr_data (w_wr_data),
    .rd_en   (w_rd_en),
    .rd_adr  (w_rd_adr),
    .rd_data (w_dout)
  );

  cv_word_buffer i_fm_buf (
    .clk     (clk),
    .wr_en   (fm_wr_en),
    .wr_adr  (fm_wr_adr),
    .wr_data (fm_wr_data),
    .rd_en   (fm_rd_en),
    .rd_adr  (fm_rd_adr),
    .rd_data (fm_dout)
  );

  //////////////////////////////////////////////////////////////////////
  // handlers and accumulator
  //////////////////////////////////////////////////////////////////////

  cv_weights_handler i_weights_handler (
    .clk            (clk),
    .reset          (reset),
    .mode           (mode),
    .re_fm_en       (re_fm_en),
    .re_fm_end      (re_fm_end),
    .weights_dout   (w_dout),
    .w_rd_en        (w_rd_en),
    .w_rd_adr       (w_rd_adr),
    .weights_vector (weights_vector),
    .weight_valid   (weight_valid)
  );

  // pixel valid doubles as the tile activity flag
  cv_pixel_handler i_pixel_handler (
    .clk          (clk),
    .reset        (reset),
    .re_fm_en     (re_fm_en),
    .re_fm_end    (re_fm_end),
    .fm_base      (fm_base),
    .fm_dout      (fm_dout),
    .fm_rd_en     (fm_rd_en),
    .fm_rd_adr    (fm_rd_adr),
    .pixel_vector (pixel_vector),
    .pixel_valid  (tile_active)
  );

  cv_dot_accumulator i_dot_accumulator (
    .clk            (clk),
    .reset          (reset),
    .weights_vector (weights_vector),
    .weight_valid   (weight_valid),
    .pixel_vector   (pixel_vector),
    .conv_result    (conv_result),
    .conv_done      (conv_done)
  );

endmodule

// ==== rtl/cv_types_pkg.sv ====
`include "cv_consts.svh"

package cv_types_pkg;

  //////////////////////////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////////////////////////

  // one buffer word, 64 byte lanes
  typedef logic [`CV_WORD_BITS-1:0] cv_word_t;

  // linear buffer address
  typedef logic [`CV_ADR_BITS-1:0] cv_adr_t;

  // operating mode
  // 0 = signed 8-bit weights, 1 = unsigned 2-bit weights
  typedef logic [3:0] cv_mode_t;

  // tile sum
  typedef logic signed [`CV_ACC_BITS-1:0] cv_acc_t;

  //////////////////////////////////////////////////////////////////////
  // accumulator FSM
  //////////////////////////////////////////////////////////////////////

  typedef enum logic {
    CV_ACC_IDLE,
    CV_ACC_RUN
  } cv_acc_state_t;

endpackage

// ==== rtl/cv_weights_handler.sv ====
`timescale 1ns/100ps
`include "cv_consts.svh"

module cv_weights_handler (
  input  logic                   clk,
  input  logic                   reset,
  input  cv_types_pkg::cv_mode_t mode,
  // tile strobes, cycle 0
  input  logic                   re_fm_en,
  input  logic                   re_fm_end,
  // buffer data, cycle 1
  input  cv_types_pkg::cv_word_t weights_dout,
  // buffer read request, cycle 0
  output logic                   w_rd_en,
  output cv_types_pkg::cv_adr_t  w_rd_adr,
  // unpacked weights, cycle 1
  output cv_types_pkg::cv_word_t weights_vector,
  output logic                   weight_valid
);

  import cv_types_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // read counter
  //////////////////////////////////////////////////////////////////////

  // counts 1..N within a tile
  cv_adr_t rd_cnt;

  // read in every strobe cycle except the end one
  assign w_rd_en = re_fm_en && !re_fm_end;

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_cnt <= cv_adr_t'(1);
    end else if (re_fm_en) begin
      // back to the first address at the tile end
      if (re_fm_end) begin
        rd_cnt <= cv_adr_t'(1);
      end else begin
        rd_cnt <= rd_cnt + cv_adr_t'(1);
      end
    end
  end

  // address is zero based
  assign w_rd_adr = rd_cnt - cv_adr_t'(1);

  //////////////////////////////////////////////////////////////////////
  // valid tracking
  //////////////////////////////////////////////////////////////////////

  // set one cycle after a read, cleared one cycle after the end strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      weight_valid <= 1'b0;
    end else if (re_fm_en) begin
      weight_valid <= !re_fm_end;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // unpacking
  //////////////////////////////////////////////////////////////////////

  // packed 2-bit weights from the low word bits
  logic [`CV_BIN_BITS-1:0] bin_bits;
  cv_word_t                bin_word;

  assign bin_bits = weights_dout[`CV_BIN_BITS-1:0];

  // lane i takes bits 2i+1 and 2i, zero extended
  for (genvar i = 0; i < `CV_LANES; i++) begin : g_bin_lane
    assign bin_word[i*8+:8] = {6'b0, bin_bits[2*i+1], bin_bits[2*i]};
  end

  // select by mode, zero outside valid cycles
  always_comb begin
    weights_vector = '0;
    if (weight_valid) begin
      case (mode)
        4'd0:    weights_vector = weights_dout;
        4'd1:    weights_vector = bin_word;
        default: weights_vector = '0;
      endcase
    end
  end

endmodule

// ==== rtl/cv_word_buffer.sv ====
`timescale 1ns/100ps
`include "cv_consts.svh"

module cv_word_buffer #(
  parameter int depth = `CV_BUF_DEPTH
) (
  input  logic                   clk,
  // write side, used while the engine is idle
  input  logic                   wr_en,
  input  cv_types_pkg::cv_adr_t  wr_adr,
  input  cv_types_pkg::cv_word_t wr_data,
  // read side, one cycle latency
  input  logic                   rd_en,
  input  cv_types_pkg::cv_adr_t  rd_adr,
  output cv_types_pkg::cv_word_t rd_data
);

  // only the low address bits select a word
  localparam int idx_bits = $clog2(depth);

  logic [`CV_WORD_BITS-1:0] mem [depth];

  // write at the clock edge
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_adr[idx_bits-1:0]] <= wr_data;
    end
  end

  // registered read
  // data holds when no read is issued
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_adr[idx_bits-1:0]];
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the tile engine testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
  -f cv_tile_engine.f --top-module cv_tile_engine_tb -o cv_tile_engine_sim \
  && ./obj_dir/cv_tile_engine_sim | tee /dev/stderr | grep -q "Result: PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== tests/cv_tile_engine_tb.sv ====
`timescale 1ns/100ps
`include "cv_consts.svh"

module cv_tile_engine_tb;

  import cv_types_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // run length
  //////////////////////////////////////////////////////////////////////

  localparam int clk_period    = 40;
  localparam int reset_cycles  = 5;
  localparam int load_cycles   = `CV_BUF_DEPTH + 1;
  // N+1 strobe cycles per tile over all groups
  localparam int tile_cycles   = 2 * (2 + 10 + 33) + (6 + 8) + (4 + 9 + 2 + 17 + 6 + 13);
  // idle gaps between groups and done latency
  localparam int margin_cycles = 100;
  localparam int watchdog_ns   =
    (reset_cycles + load_cycles + tile_cycles + margin_cycles) * clk_period;

  // DUT inputs
  logic     clk;
  logic     reset;
  cv_mode_t mode;
  logic     re_fm_en;
  logic     re_fm_end;
  cv_adr_t  fm_base;
  logic     w_wr_en;
  cv_adr_t  w_wr_adr;
  cv_word_t w_wr_data;
  logic     fm_wr_en;
  cv_adr_t  fm_wr_adr;
  cv_word_t fm_wr_data;

  // DUT outputs
  cv_acc_t  conv_result;
  logic     conv_done;
  logic     tile_active;

  // local copies of both buffers
  cv_word_t w_mem  [`CV_BUF_DEPTH];
  cv_word_t fm_mem [`CV_BUF_DEPTH];

  logic [31:0] lcg_state;
  int          cycle_cnt = 0;

  // a read was issued in the previous cycle
  logic        rd_issued = 1'b0;

  // last tile result, zero after reset
  cv_acc_t     held_val = '0;

  // pending tiles in order of issue
  cv_acc_t exp_q        [$];
  int      done_cycle_q [$];
  string   name_q       [$];

  cv_acc_t exp_val;
  int      exp_cycle;
  string   exp_name;

  // accumulator FSM state shown in the done print
  cv_acc_state_t acc_state;
  assign acc_state = i_dut.i_dot_accumulator.state;

  cv_tile_engine i_dut (
    .clk         (clk),
    .reset       (reset),
    .mode        (mode),
    .re_fm_en    (re_fm_en),
    .re_fm_end   (re_fm_end),
    .fm_base     (fm_base),
    .w_wr_en     (w_wr_en),
    .w_wr_adr    (w_wr_adr),
    .w_wr_data   (w_wr_data),
    .fm_wr_en    (fm_wr_en),
    .fm_wr_adr   (fm_wr_adr),
    .fm_wr_data  (fm_wr_data),
    .conv_result (conv_result),
    .conv_done   (conv_done),
    .tile_active (tile_active)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // cycle index of the current clock period
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // pixels are valid in the cycle after each read
  always @(posedge clk) begin
    rd_issued <= re_fm_en && !re_fm_end;
  end

  //////////////////////////////////////////////////////////////////////
  // random data and reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic cv_word_t random_word();
    cv_word_t word;
    for (int j = 0; j < `CV_WORD_BITS / 32; j++) begin
      word[32*j+:32] = lcg_next();
    end
    return word;
  endfunction

  // base keeps the whole tile inside the buffer
  function automatic cv_adr_t random_base(input int n);
    logic [31:0] r;
    r = lcg_next() >> 8;
    return cv_adr_t'(r % 32'(`CV_BUF_DEPTH - n + 1));
  endfunction

  // tile sum over N words with weights from 0 and pixels from base
  function automatic cv_acc_t tile_sum(input cv_mode_t m, input cv_adr_t base, input int n);
    cv_word_t wword;
    cv_word_t pword;
    int       w;
    int       p;
    int       sum;
    sum = 0;
    for (int k = 0; k < n; k++) begin
      wword = w_mem[k];
      pword = fm_mem[int'(base) + k];
      for (int i = 0; i < `CV_LANES; i++) begin
        if (m == 4'd0) begin
          // signed byte
          w = int'($signed(wword[8*i+:8]));
        end else if (m == 4'd1) begin
          // unsigned 2-bit pair
          w = int'({30'b0, wword[2*i+1], wword[2*i]});
        end else begin
          w = 0;
        end
        p = int'({24'b0, pword[8*i+:8]});
        sum = sum + w * p;
      end
    end
    return cv_acc_t'(sum);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
      $display("Result: FAILED");
      $fatal(1);
    end
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  // outputs sampled mid cycle
  always @(negedge clk) begin
    if (!reset) begin
      check_value("tile_active", int'(rd_issued), int'(tile_active));
      if (conv_done) begin
        if (exp_q.size() == 0) begin
          report_failure("conv_done pulsed while no tile was pending");
        end else begin
          exp_val   = exp_q.pop_front();
          exp_cycle = done_cycle_q.pop_front();
          exp_name  = name_q.pop_front();
          $display("tile %s done: result %0d, accumulator %s",
                   exp_name, conv_result, acc_state.name());
          check_value({exp_name, " result"}, exp_val, conv_result);
          check_value({exp_name, " done cycle"}, exp_cycle, cycle_cnt);
          held_val = exp_val;
        end
      end else begin
        // result holds until the next done
        check_value("held conv_result", held_val, conv_result);
        if (done_cycle_q.size() != 0 && cycle_cnt > done_cycle_q[0]) begin
          report_failure({"conv_done never arrived for tile ", name_q[0]});
        end
      end
    end
  end

  initial begin
    #(watchdog_ns);
    report_failure("watchdog expired before all tiles completed");
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic drive_idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #2;
      re_fm_en  = 1'b0;
      re_fm_end = 1'b0;
    end
  endtask

  // both buffers in parallel with one word per cycle
  task automatic load_buffers();
    cv_word_t wword;
    cv_word_t pword;
    for (int a = 0; a < `CV_BUF_DEPTH; a++) begin
      wword     = random_word();
      pword     = random_word();
      w_mem[a]  = wword;
      fm_mem[a] = pword;
      @(posedge clk);
      #2;
      w_wr_en    = 1'b1;
      w_wr_adr   = cv_adr_t'(a);
      w_wr_data  = wword;
      fm_wr_en   = 1'b1;
      fm_wr_adr  = cv_adr_t'(a);
      fm_wr_data = pword;
    end
    @(posedge clk);
    #2;
    w_wr_en  = 1'b0;
    fm_wr_en = 1'b0;
  endtask

  // N+1 strobe cycles with the end strobe on the last
  task automatic run_tile(input string name, input cv_mode_t m, input cv_adr_t base,
                          input int n);
    for (int k = 0; k <= n; k++) begin
      @(posedge clk);
      #2;
      mode      = m;
      fm_base   = base;
      re_fm_en  = 1'b1;
      re_fm_end = (k == n);
    end
    // done one cycle after the end strobe
    exp_q.push_back(tile_sum(m, base, n));
    done_cycle_q.push_back(cycle_cnt + 1);
    name_q.push_back(name);
  endtask

  initial begin
    reset      = 1'b1;
    mode       = '0;
    re_fm_en   = 1'b0;
    re_fm_end  = 1'b0;
    fm_base    = '0;
    w_wr_en    = 1'b0;
    w_wr_adr   = '0;
    w_wr_data  = '0;
    fm_wr_en   = 1'b0;
    fm_wr_adr  = '0;
    fm_wr_data = '0;
    lcg_state  = 32'd79607;
    repeat (reset_cycles) @(posedge clk);
    #2;
    reset = 1'b0;

    load_buffers();
    drive_idle(4);

    // signed 8-bit weights
    run_tile("mode0_n1", 4'd0, random_base(1), 1);
    drive_idle(3);
    run_tile("mode0_n9", 4'd0, random_base(9), 9);
    drive_idle(3);
    run_tile("mode0_n32", 4'd0, random_base(32), 32);
    drive_idle(3);

    // 2-bit weights from the same buffers
    run_tile("mode1_n1", 4'd1, random_base(1), 1);
    drive_idle(3);
    run_tile("mode1_n9", 4'd1, random_base(9), 9);
    drive_idle(3);
    run_tile("mode1_n32", 4'd1, random_base(32), 32);
    drive_idle(3);

    // unsupported modes sum to zero
    run_tile("mode2_n5", 4'd2, random_base(5), 5);
    drive_idle(3);
    run_tile("mode15_n7", 4'd15, random_base(7), 7);
    drive_idle(3);

    // back to back tiles where done overlaps the next reads
    run_tile("b2b_0", 4'd0, random_base(3), 3);
    run_tile("b2b_1", 4'd1, random_base(8), 8);
    run_tile("b2b_2", 4'd0, random_base(1), 1);
    run_tile("b2b_3", 4'd1, random_base(16), 16);
    run_tile("b2b_4", 4'd0, random_base(5), 5);
    run_tile("b2b_5", 4'd1, random_base(12), 12);
    drive_idle(4);

    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    drive_idle(4);
    $display("Result: PASSED");
    $finish;
  end

endmodule
